//--- uart_macros.svh
//////////////////////////////////////////////////////////////////////
// UART timing and format
//////////////////////////////////////////////////////////////////////

`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// clock cycles per bit period, must be even
`define UART_CLKS_PER_BIT 16

// receiver works in half-bit steps
`define UART_HALF_BIT (`UART_CLKS_PER_BIT / 2)

// 8N1 frame
`define UART_DATA_BITS 8

`endif

//--- uart_pkg.sv
//////////////////////////////////////////////////////////////////////
// UART shared types
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "uart_macros.svh"

package uart_pkg;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP,
        TX_DONE
    } tx_state_e;

    // received byte plus its status flags
    typedef struct packed {
        logic [`UART_DATA_BITS-1:0] data;
        logic                       frame_err;
        logic                       overrun;
    } rx_word_t;

endpackage

`default_nettype wire

//--- uart_rx.sv
//////////////////////////////////////////////////////////////////////
// UART serial receiver
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "uart_macros.svh"

module uart_rx (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx_line,
    output logic               rx_valid,
    output uart_pkg::rx_word_t rx_word
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(`UART_HALF_BIT + 1);
    localparam int BIT_W = $clog2(`UART_DATA_BITS);
    localparam logic [CNT_W-1:0] HALF_MAX = CNT_W'(`UART_HALF_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`UART_DATA_BITS - 1);

    rx_state_e                  state;
    logic [2:0]                 sync_q;
    logic                       rx_s;
    logic                       fall;
    logic [CNT_W-1:0]           cnt;
    logic                       half_tick;
    logic                       half_phase;
    logic                       sample;
    logic [BIT_W-1:0]           bit_idx;
    logic                       stop_seen;
    logic                       data_sample;
    logic                       stop_sample;
    logic [`UART_DATA_BITS-1:0] shift_q;
    logic                       ferr_q;

    // two sync stages, third bit only for edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[1:0], rx_line};
        end
    end

    assign rx_s = sync_q[1];
    assign fall = sync_q[2] & ~sync_q[1];

    assign half_tick   = (cnt == HALF_MAX);
    // every second half tick lands on mid-bit
    assign sample      = half_tick & half_phase;
    assign data_sample = (state == RX_DATA) & sample;
    assign stop_sample = (state == RX_STOP) & ~stop_seen & sample;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= RX_IDLE;
            cnt        <= '0;
            half_phase <= 1'b0;
            bit_idx    <= '0;
            stop_seen  <= 1'b0;
            rx_valid   <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (state == RX_IDLE || half_tick) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end

            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // still low at mid start bit, else a glitch
                    if (half_tick) begin
                        if (!rx_s) begin
                            state      <= RX_DATA;
                            half_phase <= 1'b0;
                            bit_idx    <= '0;
                        end else begin
                            state <= RX_IDLE;
                        end
                    end
                end
                RX_DATA: begin
                    if (half_tick) begin
                        half_phase <= ~half_phase;
                    end
                    if (data_sample) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == LAST_BIT) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (stop_seen) begin
                        // a low stop bit keeps us here until the line idles
                        if (rx_s) begin
                            state     <= RX_IDLE;
                            stop_seen <= 1'b0;
                        end
                    end else if (half_tick) begin
                        half_phase <= ~half_phase;
                        if (half_phase) begin
                            stop_seen <= 1'b1;
                            rx_valid  <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // lsb first
    always_ff @(posedge clk) begin
        if (data_sample) begin
            shift_q <= {rx_s, shift_q[`UART_DATA_BITS-1:1]};
        end
        if (stop_sample) begin
            ferr_q <= ~rx_s;
        end
    end

    assign rx_word = '{data: shift_q, frame_err: ferr_q, overrun: 1'b0};

endmodule

`default_nettype wire

//--- uart_rx_buffer.sv
//////////////////////////////////////////////////////////////////////
// UART receive holding stage
//////////////////////////////////////////////////////////////////////

`default_nettype none

module uart_rx_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx_valid,
    input  uart_pkg::rx_word_t rx_word_in,
    output logic               rx_req,
    input  logic               rx_ack,
    output uart_pkg::rx_word_t rx_word
);
    import uart_pkg::*;

    rx_word_t word_q;
    logic     ovr_q;
    logic     busy;
    logic     capture;

    // held from req rise until the host has released ack
    assign busy    = rx_req | rx_ack;
    assign capture = rx_valid & ~busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_req <= 1'b0;
            ovr_q  <= 1'b0;
        end else begin
            if (capture) begin
                rx_req <= 1'b1;
                ovr_q  <= 1'b0;
            end else if (rx_req && rx_ack) begin
                rx_req <= 1'b0;
            end

            // byte lost, flag it on the next word taken
            if (rx_valid && busy) begin
                ovr_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            word_q <= '{data:      rx_word_in.data,
                        frame_err: rx_word_in.frame_err,
                        overrun:   ovr_q};
        end
    end

    assign rx_word = word_q;

endmodule

`default_nettype wire

//--- uart_tx.sv
//////////////////////////////////////////////////////////////////////
// UART serial transmitter
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "uart_macros.svh"

module uart_tx (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       tx_req,
    input  logic [`UART_DATA_BITS-1:0] tx_data,
    output logic                       tx_ack,
    output logic                       tx_line
);
    import uart_pkg::*;

    localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
    localparam int BIT_W = $clog2(`UART_DATA_BITS);
    localparam logic [CNT_W-1:0] BIT_MAX  = CNT_W'(`UART_CLKS_PER_BIT - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`UART_DATA_BITS - 1);

    tx_state_e                  state;
    logic [CNT_W-1:0]           cnt;
    logic                       bit_end;
    logic [BIT_W-1:0]           bit_idx;
    logic [`UART_DATA_BITS-1:0] shift_q;
    logic                       load;
    logic                       shift;

    assign bit_end = (cnt == BIT_MAX);
    assign load    = (state == TX_IDLE) & tx_req;
    // next data bit goes out at the end of start and each data bit
    assign shift   = bit_end & ((state == TX_START) | (state == TX_DATA));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx_line <= 1'b1;
        end else begin
            if (state == TX_IDLE || state == TX_DONE || bit_end) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end

            case (state)
                TX_IDLE: begin
                    tx_line <= 1'b1;
                    if (tx_req) begin
                        state   <= TX_START;
                        tx_line <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx_line <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == LAST_BIT) begin
                            state   <= TX_STOP;
                            tx_line <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx_line <= shift_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_DONE;
                    end
                end
                TX_DONE: begin
                    // wait for the host to release req
                    if (!tx_req) begin
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state   <= TX_IDLE;
                    tx_line <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= tx_data;
        end else if (shift) begin
            shift_q <= shift_q >> 1;
        end
    end

    // falls together with req
    assign tx_ack = (state == TX_DONE) & tx_req;

endmodule

`default_nettype wire

//--- uart_core.sv
//////////////////////////////////////////////////////////////////////
// UART link top level
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "uart_macros.svh"

module uart_core (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rx_line,
    output logic                       tx_line,
    output logic                       rx_req,
    input  logic                       rx_ack,
    output uart_pkg::rx_word_t         rx_word,
    input  logic                       tx_req,
    input  logic [`UART_DATA_BITS-1:0] tx_data,
    output logic                       tx_ack
);
    import uart_pkg::*;

    logic     rx_valid;
    rx_word_t rx_word_raw;

    uart_rx u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_line  (rx_line),
        .rx_valid (rx_valid),
        .rx_word  (rx_word_raw)
    );

    // host side of the receive path
    uart_rx_buffer u_rx_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_valid   (rx_valid),
        .rx_word_in (rx_word_raw),
        .rx_req     (rx_req),
        .rx_ack     (rx_ack),
        .rx_word    (rx_word)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .tx_req  (tx_req),
        .tx_data (tx_data),
        .tx_ack  (tx_ack),
        .tx_line (tx_line)
    );

endmodule

`default_nettype wire

//--- uart_core_props.sv
//////////////////////////////////////////////////////////////////////
// UART link assertions
//////////////////////////////////////////////////////////////////////

`default_nettype none

module uart_core_props (
    input logic                clk,
    input logic                rst_n,
    input logic                rx_req,
    input logic                rx_ack,
    input uart_pkg::rx_word_t  rx_word,
    input logic                tx_line,
    input logic                tx_req,
    input logic                tx_ack,
    input uart_pkg::tx_state_e tx_state
);
    import uart_pkg::*;

    int fail_count = 0;

    req_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(rx_req) |-> $past(rx_ack))
        else begin
            $error("rx_req dropped without rx_ack");
            fail_count++;
        end

    word_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rx_req && $past(rx_req) |-> $stable(rx_word))
        else begin
            $error("rx_word changed while rx_req was high");
            fail_count++;
        end

    idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        tx_state == TX_IDLE |-> tx_line)
        else begin
            $error("tx_line low while the transmitter is idle");
            fail_count++;
        end

    // four-phase order on the transmit side
    tx_req_held_for_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(tx_req) |-> $past(tx_ack))
        else begin
            $error("tx_req dropped before tx_ack");
            fail_count++;
        end

endmodule

bind uart_core uart_core_props u_props (.*, .tx_state(u_tx.state));

`default_nettype wire

//--- uart_core_checker.sv
//////////////////////////////////////////////////////////////////////
// UART link checker
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "uart_macros.svh"

module uart_core_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rx_req,
    input  uart_pkg::rx_word_t rx_word,
    input  logic               tx_line,
    input  logic               tx_req,
    input  logic [7:0]         tx_data,
    input  logic               tx_ack,
    input  logic               exp_push,
    input  uart_pkg::rx_word_t exp_word,
    input  logic [63:0]        exp_name,
    output int                 chk_errors
);
    import uart_pkg::*;

    rx_word_t    want_q[$];
    logic [63:0] name_q[$];
    logic [7:0]  tx_q[$];
    rx_word_t    want;
    logic [63:0] name;
    logic [7:0]  tx_got;
    logic [7:0]  tx_want;
    logic        rx_req_d;
    logic        tx_req_d;
    logic        tx_ack_d;
    logic        idle_checked;
    logic        tx_busy;
    int          tx_wait;
    int          tx_bit;

    // sample between DUT updates
    always @(negedge clk) begin
        if (!rst_n) begin
            chk_errors   = 0;
            rx_req_d     = 1'b0;
            tx_req_d     = 1'b0;
            tx_ack_d     = 1'b0;
            idle_checked = 1'b0;
            tx_busy      = 1'b0;
        end else begin
            if (!idle_checked) begin
                idle_checked = 1'b1;
                if (tx_line !== 1'b1 || rx_req !== 1'b0 || tx_ack !== 1'b0) begin
                    $display("outputs not idle after reset: tx_line %b rx_req %b tx_ack %b",
                             tx_line, rx_req, tx_ack);
                    chk_errors++;
                end
            end
            if (exp_push) begin
                want_q.push_back(exp_word);
                name_q.push_back(exp_name);
            end
            if (rx_req && !rx_req_d) begin
                if (want_q.size() == 0) begin
                    $display("rx_req rose with no word expected, data %h", rx_word.data);
                    chk_errors++;
                end else begin
                    want = want_q.pop_front();
                    name = name_q.pop_front();
                    if (rx_word !== want) begin
                        $display("Fail %0s: expected %h ferr %b ovr %b, actual %h ferr %b ovr %b",
                                 name, want.data, want.frame_err, want.overrun,
                                 rx_word.data, rx_word.frame_err, rx_word.overrun);
                        chk_errors++;
                    end
                end
            end
            if (tx_req && !tx_req_d) begin
                tx_q.push_back(tx_data);
            end
            // tx_line decode at mid-bit
            if (!tx_busy) begin
                if (!tx_line) begin
                    tx_busy = 1'b1;
                    tx_wait = `UART_HALF_BIT;
                    tx_bit  = 0;
                end
            end else begin
                tx_wait--;
                if (tx_wait == 0) begin
                    tx_wait = `UART_CLKS_PER_BIT;
                    if (tx_bit == 0 && tx_line !== 1'b0) begin
                        $display("tx start bit was not low at mid-bit");
                        chk_errors++;
                        tx_busy = 1'b0;
                    end else if (tx_bit >= 1 && tx_bit <= `UART_DATA_BITS) begin
                        tx_got[tx_bit-1] = tx_line;
                    end else if (tx_bit > `UART_DATA_BITS) begin
                        tx_busy = 1'b0;
                        if (tx_line !== 1'b1) begin
                            $display("Fail TX stop: expected 1, actual %b", tx_line);
                            chk_errors++;
                        end
                        if (tx_q.size() == 0) begin
                            $display("frame on tx_line without a transmit request");
                            chk_errors++;
                        end else begin
                            tx_want = tx_q.pop_front();
                            if (tx_got !== tx_want) begin
                                $display("Fail TX: expected %h, actual %h", tx_want, tx_got);
                                chk_errors++;
                            end
                        end
                    end
                    tx_bit++;
                end
            end
            if (tx_ack && !tx_ack_d && (tx_busy || tx_q.size() != 0)) begin
                $display("tx_ack rose before a full frame appeared on tx_line");
                chk_errors++;
            end
            rx_req_d = rx_req;
            tx_req_d = tx_req;
            tx_ack_d = tx_ack;
        end
    end

endmodule

`default_nettype wire

//--- tb_uart_core.sv
//////////////////////////////////////////////////////////////////////
// UART link testbench
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "uart_macros.svh"

module tb_uart_core;
    import uart_pkg::*;

    logic         clk;
    logic         rst_n;
    logic         rx_line;
    logic         rx_ack;
    logic         tx_req;
    logic [7:0]   tx_data;
    logic         rx_req;
    logic         tx_ack;
    logic         tx_line;
    rx_word_t     rx_word;
    logic         exp_push;
    rx_word_t     exp_word;
    logic [63:0]  exp_name;
    int           chk_errors;
    int           tb_errors;
    int           fd;
    logic [639:0] line_buf;
    logic [63:0]  op;
    logic [7:0]   byte_val;
    logic         stop_val;
    logic         held;
    logic         ovr_pending;

    uart_core DUT (.*);
    uart_core_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic wait_level(input bit on_tx, input logic level, input int limit);
        int n;
        n = 0;
        while ((on_tx ? tx_ack : rx_req) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if ((on_tx ? tx_ack : rx_req) !== level) begin
            $display("timeout waiting for %0s to go %b", on_tx ? "tx_ack" : "rx_req", level);
            tb_errors++;
        end
    endtask

    // start, 8 data bits lsb first, stop, one idle bit
    task automatic send_frame(input logic [7:0] d, input logic s);
        logic [10:0] bits;
        int          i;
        bits = {1'b1, s, d, 1'b0};
        for (i = 0; i < 11; i++) begin
            @(posedge clk);
            rx_line <= bits[i];
            repeat (`UART_CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic expect_word(input logic [63:0] name, input logic [7:0] d, input logic s);
        @(posedge clk);
        exp_push <= 1'b1;
        exp_word <= '{data: d, frame_err: ~s, overrun: ovr_pending};
        exp_name <= name;
        ovr_pending = 1'b0;
        @(posedge clk);
        exp_push <= 1'b0;
    endtask

    task automatic ack_word();
        repeat ($urandom % 6) @(posedge clk);
        @(posedge clk);
        rx_ack <= 1'b1;
        wait_level(1'b0, 1'b0, 8);
        @(posedge clk);
        rx_ack <= 1'b0;
    endtask

    task automatic release_held();
        if (held) begin
            ack_word();
            held = 1'b0;
        end
    endtask

    task automatic send_byte(input logic [7:0] d);
        @(posedge clk);
        tx_data <= d;
        tx_req  <= 1'b1;
        wait_level(1'b1, 1'b1, 12 * `UART_CLKS_PER_BIT);
        @(posedge clk);
        tx_req <= 1'b0;
        wait_level(1'b1, 1'b0, 4);
    endtask

    task automatic run_vector(input logic [63:0] name, input logic [7:0] d, input logic s);
        if (name == "RX" || (name == "RXOVR" && !held)) begin
            release_held();
            expect_word(name, d, s);
            send_frame(d, s);
            wait_level(1'b0, 1'b1, 2 * `UART_CLKS_PER_BIT);
            if (name == "RX") begin
                ack_word();
            end else begin
                held = 1'b1;
            end
        end else if (name == "RXOVR") begin
            // handshake still open so this byte is lost
            send_frame(d, s);
            ovr_pending = 1'b1;
        end else if (name == "GLITCH") begin
            @(posedge clk);
            rx_line <= 1'b0;
            repeat (d) @(posedge clk);
            rx_line <= 1'b1;
            repeat (2 * `UART_CLKS_PER_BIT) @(posedge clk);
        end else if (name == "TX") begin
            send_byte(d);
        end else begin
            $display("unknown operation %0s in the input file", name);
            tb_errors++;
        end
    endtask

    initial begin
        void'($urandom(46));
        rst_n       = 1'b0;
        rx_line     = 1'b1;
        rx_ack      = 1'b0;
        tx_req      = 1'b0;
        tx_data     = '0;
        exp_push    = 1'b0;
        exp_word    = '0;
        exp_name    = '0;
        tb_errors   = 0;
        held        = 1'b0;
        ovr_pending = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        fd = $fopen("uart_core_input.txt", "r");
        if (fd == 0) begin
            $display("could not open uart_core_input.txt");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line_buf = '0;
                if ($fgets(line_buf, fd) != 0) begin
                    if ($sscanf(line_buf, "%s %h %b", op, byte_val, stop_val) == 3) begin
                        run_vector(op, byte_val, stop_val);
                    end
                end
            end
            $fclose(fd);
        end
        release_held();
        repeat (2 * `UART_CLKS_PER_BIT) @(posedge clk);

        $display("checker errors %0d, testbench errors %0d, assertion errors %0d",
                 chk_errors, tb_errors, DUT.u_props.fail_count);
        if (chk_errors == 0 && tb_errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_core.f
+incdir+.
uart_pkg.sv
uart_rx.sv
uart_rx_buffer.sv
uart_tx.sv
uart_core.sv
uart_core_props.sv
uart_core_checker.sv
tb_uart_core.sv

//--- uart_core_input.txt
# op  byte(hex)  stop_bit    ops are RX, RXOVR, TX, GLITCH
# GLITCH takes the byte as its low pulse width in clocks
RX 55 1
RX a3 1
RX 00 1
RX ff 1
RX 3c 0
GLITCH 03 1
RX 81 1
TX a5 1
TX 01 1
TX 7e 1
RXOVR 12 1
RXOVR 34 1
RX 56 1
RX c9 0
